// File: list.f
src/stream_pkg.sv
src/source_ctrl_pkg.sv
src/source_addrgen.sv
src/source_wb_reader.sv
src/source_realign.sv
src/stream_source.sv
verif/tb_wb_mem.sv
verif/stream_source_props.sv
verif/tb_stream_source.sv

// File: run.sh
#!/usr/bin/env bash
# builds the stream source testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_stream_source -f list.f -Mdir obj_dir

out="$(./obj_dir/Vtb_stream_source)"
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: src/source_addrgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first stage: turns a start command into word requests
// flags first and last, and gives the strobe of the first word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module source_addrgen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  stream_pkg::addr_t      addr_i,
  input  source_ctrl_pkg::len_t  words_i,
  input  logic                   last_done_i,
  output logic                   busy_o,
  output logic                   req_valid_o,
  input  logic                   req_ready_i,
  output stream_pkg::addr_t      req_addr_o,
  output logic                   req_first_o,
  output logic                   req_last_o,
  output stream_pkg::strb_t      req_strb_o
);

  import stream_pkg::*;
  import source_ctrl_pkg::*;

  addrgen_state_e state_q;

  logic             busy_q;
  logic             first_q;
  len_t             cnt_q;
  addr_t            addr_q;
  strb_t            strb_q;
  strb_t            first_strb;
  logic [OFFS_W-1:0] offs;
  logic             start_ok;
  logic             req_hs;

  assign offs     = addr_i[OFFS_W-1:0];
  assign start_ok = start_i & ~busy_q;
  assign req_hs   = req_valid_o & req_ready_i;

  // lanes at or above the offset hold wanted bytes
  always_comb begin
    for (int j = 0; j < BYTES_PER_WORD; j++) begin
      first_strb[j] = (j >= int'(offs));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= AG_IDLE;
      busy_q  <= 1'b0;
      first_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      // busy lasts until the realigner has sent the last word
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (last_done_i) begin
        busy_q <= 1'b0;
      end
      case (state_q)
        AG_IDLE: begin
          if (start_ok) begin
            state_q <= AG_ISSUE;
            first_q <= 1'b1;
            // cnt holds the requests left minus one, one extra when misaligned
            cnt_q   <= (offs != '0) ? words_i : len_t'(words_i - 1'b1);
          end
        end
        AG_ISSUE: begin
          if (req_hs) begin
            first_q <= 1'b0;
            cnt_q   <= cnt_q - 1'b1;
            if (cnt_q == '0) begin
              state_q <= AG_IDLE;
            end
          end
        end
        default: state_q <= AG_IDLE;
      endcase
    end
  end

  // word address and first strobe
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      addr_q <= {addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
      strb_q <= first_strb;
    end else if (req_hs) begin
      addr_q <= addr_q + addr_t'(BYTES_PER_WORD);
    end
  end

  assign busy_o      = busy_q;
  assign req_valid_o = (state_q == AG_ISSUE);
  assign req_addr_o  = addr_q;
  assign req_first_o = first_q;
  assign req_last_o  = (cnt_q == '0);
  assign req_strb_o  = first_q ? strb_q : '1;

endmodule

// File: src/source_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control types of the stream source
// length type and the state encodings of the stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package source_ctrl_pkg;

  // width of the transfer length
  localparam int unsigned LEN_W = 16;

  // count of output words in one transfer
  typedef logic [LEN_W-1:0] len_t;

  // address generator
  typedef enum logic {
    AG_IDLE,
    AG_ISSUE
  } addrgen_state_e;

  // wishbone reader waits for a request, runs the bus cycle, then holds the word
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_BUS,
    RD_HOLD
  } reader_state_e;

endpackage

// File: src/source_realign.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// third stage: merges consecutive fetched words by the byte offset
// zero latency from the word stream to the output stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module source_realign (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wd_valid_i,
  output logic              wd_ready_o,
  input  stream_pkg::data_t wd_data_i,
  input  logic              wd_first_i,
  input  logic              wd_last_i,
  input  stream_pkg::strb_t wd_strb_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output stream_pkg::data_t out_data_o,
  output logic              out_last_o,
  output logic              last_done_o
);

  import stream_pkg::*;

  rot_t  rot_d;
  rot_t  rot_q;
  rot_t  rot_cur;
  rot_t  rot_inv;
  data_t prev_q;
  data_t merged;
  logic  realign;
  logic  absorb;
  logic  wd_hs;

  logic [ROT_W+2:0] sh_cur;
  logic [ROT_W+2:0] sh_prev;

  // valid bytes of the first word
  always_comb begin
    rot_d = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      rot_d = rot_d + rot_t'(wd_strb_i[i]);
    end
  end

  // the first word decides on its own strobe, later words use the stored count
  assign rot_cur = wd_first_i ? rot_d : rot_q;
  assign rot_inv = rot_t'(BYTES_PER_WORD) - rot_cur;
  assign realign = (rot_cur != '0) && (rot_cur != rot_t'(BYTES_PER_WORD));

  // a misaligned first word only fills the previous-word register
  assign absorb = wd_first_i & realign;

  // byte counts turned into bit shifts
  assign sh_cur  = {rot_cur, 3'b000};
  assign sh_prev = {rot_inv, 3'b000};

  // upper bytes of the previous word go to the low lanes
  assign merged = (wd_data_i << sh_cur) | (prev_q >> sh_prev);

  assign out_data_o  = realign ? merged : wd_data_i;
  assign out_valid_o = wd_valid_i & ~absorb;
  assign out_last_o  = wd_last_i;
  assign wd_ready_o  = absorb ? 1'b1 : out_ready_i;

  assign wd_hs       = wd_valid_i & wd_ready_o;
  assign last_done_o = out_valid_o & out_ready_i & out_last_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rot_q <= '0;
    end else if (wd_hs && wd_first_i) begin
      rot_q <= rot_d;
    end
  end

  // previous word, kept for the next merge
  always_ff @(posedge clk_i) begin
    if (wd_hs) begin
      prev_q <= wd_data_i;
    end
  end

endmodule

// File: src/source_wb_reader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// second stage: one wishbone classic read per request
// the fetched word leaves together with the request flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module source_wb_reader (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  stream_pkg::addr_t req_addr_i,
  input  logic              req_first_i,
  input  logic              req_last_i,
  input  stream_pkg::strb_t req_strb_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output stream_pkg::addr_t wb_adr_o,
  input  stream_pkg::data_t wb_dat_i,
  input  logic              wb_ack_i,
  output logic              wd_valid_o,
  input  logic              wd_ready_i,
  output stream_pkg::data_t wd_data_o,
  output logic              wd_first_o,
  output logic              wd_last_o,
  output stream_pkg::strb_t wd_strb_o
);

  import stream_pkg::*;
  import source_ctrl_pkg::*;

  reader_state_e state_q;

  addr_t adr_q;
  data_t data_q;
  strb_t strb_q;
  logic  first_q;
  logic  last_q;
  logic  req_hs;

  assign req_hs = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: if (req_hs) state_q <= RD_BUS;
        RD_BUS: if (wb_ack_i) state_q <= RD_HOLD;
        RD_HOLD: if (wd_ready_i) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // request fields ride along with the bus cycle
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      adr_q   <= req_addr_i;
      first_q <= req_first_i;
      last_q  <= req_last_i;
      strb_q  <= req_strb_i;
    end
    if ((state_q == RD_BUS) && wb_ack_i) begin
      data_q <= wb_dat_i;
    end
  end

  // one request at a time
  assign req_ready_o = (state_q == RD_IDLE);

  assign wb_cyc_o = (state_q == RD_BUS);
  assign wb_stb_o = (state_q == RD_BUS);
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;

  assign wd_valid_o = (state_q == RD_HOLD);
  assign wd_data_o  = data_q;
  assign wd_first_o = first_q;
  assign wd_last_o  = last_q;
  assign wd_strb_o  = strb_q;

endmodule

// File: src/stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and vector types of the data path
// import where words, strobes or addresses are handled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stream_pkg;

  // bus and stream word geometry
  localparam int unsigned DATA_W         = 32;
  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned BYTES_PER_WORD = DATA_W / 8;

  // byte offset inside a word
  localparam int unsigned OFFS_W = $clog2(BYTES_PER_WORD);

  // a byte count from 0 up to a full word needs one extra bit
  localparam int unsigned ROT_W = OFFS_W + 1;

  // one memory or stream word
  typedef logic [DATA_W-1:0] data_t;

  // one bit per byte lane
  typedef logic [BYTES_PER_WORD-1:0] strb_t;

  // byte address on the bus
  typedef logic [ADDR_W-1:0] addr_t;

  // number of valid bytes in the first fetched word
  typedef logic [ROT_W-1:0] rot_t;

endpackage

// File: src/stream_source.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-aligned stream source, top level
// address generator, wishbone reader and realigner in a row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module stream_source (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  stream_pkg::addr_t     addr_i,
  input  source_ctrl_pkg::len_t words_i,
  output logic                  busy_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output stream_pkg::addr_t     wb_adr_o,
  input  stream_pkg::data_t     wb_dat_i,
  input  logic                  wb_ack_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output stream_pkg::data_t     out_data_o,
  output logic                  out_last_o
);

  import stream_pkg::*;

  // request stream
  logic  req_valid;
  logic  req_ready;
  addr_t req_addr;
  logic  req_first;
  logic  req_last;
  strb_t req_strb;

  // word stream
  logic  wd_valid;
  logic  wd_ready;
  data_t wd_data;
  logic  wd_first;
  logic  wd_last;
  strb_t wd_strb;

  logic  last_done;

  source_addrgen i_addrgen (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .start_i     ( start_i   ),
    .addr_i      ( addr_i    ),
    .words_i     ( words_i   ),
    .last_done_i ( last_done ),
    .busy_o      ( busy_o    ),
    .req_valid_o ( req_valid ),
    .req_ready_i ( req_ready ),
    .req_addr_o  ( req_addr  ),
    .req_first_o ( req_first ),
    .req_last_o  ( req_last  ),
    .req_strb_o  ( req_strb  )
  );

  source_wb_reader i_reader (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .req_valid_i ( req_valid ),
    .req_ready_o ( req_ready ),
    .req_addr_i  ( req_addr  ),
    .req_first_i ( req_first ),
    .req_last_i  ( req_last  ),
    .req_strb_i  ( req_strb  ),
    .wb_cyc_o    ( wb_cyc_o  ),
    .wb_stb_o    ( wb_stb_o  ),
    .wb_we_o     ( wb_we_o   ),
    .wb_adr_o    ( wb_adr_o  ),
    .wb_dat_i    ( wb_dat_i  ),
    .wb_ack_i    ( wb_ack_i  ),
    .wd_valid_o  ( wd_valid  ),
    .wd_ready_i  ( wd_ready  ),
    .wd_data_o   ( wd_data   ),
    .wd_first_o  ( wd_first  ),
    .wd_last_o   ( wd_last   ),
    .wd_strb_o   ( wd_strb   )
  );

  source_realign i_realign (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .wd_valid_i  ( wd_valid    ),
    .wd_ready_o  ( wd_ready    ),
    .wd_data_i   ( wd_data     ),
    .wd_first_i  ( wd_first    ),
    .wd_last_i   ( wd_last     ),
    .wd_strb_i   ( wd_strb     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( out_data_o  ),
    .out_last_o  ( out_last_o  ),
    .last_done_o ( last_done   )
  );

endmodule

// File: verif/stream_source_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions on the wishbone port and the output stream
// bound into every stream_source instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module stream_source_props (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              wb_cyc_o,
  input logic              wb_stb_o,
  input stream_pkg::addr_t wb_adr_o,
  input logic              wb_ack_i,
  input logic              out_valid_o,
  input logic              out_ready_i,
  input stream_pkg::data_t out_data_o,
  input logic              out_last_o
);

  // stb and cyc stay up together until the slave acks
  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && wb_cyc_o))
    else $error("wb_stb_o or wb_cyc_o dropped before ack");

  // address held until the slave acks
  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
    else $error("wb_adr_o changed during a bus cycle");

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> ($stable(out_data_o) && $stable(out_last_o)))
    else $error("output word changed while stalled");

endmodule

bind stream_source stream_source_props i_props (.*);

// File: verif/tb_stream_source.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LFSR driven transfers through the stream source
// checked word by word against a byte model of the memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_stream_source;

  import stream_pkg::*;
  import source_ctrl_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 400;

  logic        clk_i;
  logic        rst_ni;
  logic        start_i;
  addr_t       addr_i;
  len_t        words_i;
  logic        busy_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  addr_t       wb_adr_o;
  data_t       wb_dat_i;
  logic        wb_ack_i;
  logic        out_valid_o;
  logic        out_ready_i;
  data_t       out_data_o;
  logic        out_last_o;
  logic [1:0]  mem_wait;
  logic [31:0] lfsr_q;
  data_t       model_mem [MEM_WORDS];
  int          errors;
  int          tests;

  stream_source uut (.*);

  tb_wb_mem u_mem (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .cyc_i  ( wb_cyc_o ),
    .stb_i  ( wb_stb_o ),
    .adr_i  ( wb_adr_o ),
    .wait_i ( mem_wait ),
    .dat_o  ( wb_dat_i ),
    .ack_o  ( wb_ack_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // output word k holds the bytes at a+4k up to a+4k+3 in little-endian order
  function automatic data_t model_word(input addr_t a, input int k);
    data_t w;
    addr_t b;
    for (int i = 0; i < 4; i++) begin
      b = a + addr_t'(4 * k + i);
      w[8*i +: 8] = model_mem[b[9:2]][8*b[1:0] +: 8];
    end
    return w;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_last(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // bp gives random ready, ws random wait states and poke a second start while busy
  task automatic run_transfer(input string what, input addr_t a, input len_t n,
                              input logic bp, input logic ws, input logic poke);
    int          got;
    int          cyc;
    int          err0;
    logic [31:0] r;
    got  = 0;
    cyc  = 0;
    err0 = errors;
    @(posedge clk_i);
    start_i     <= 1'b1;
    addr_i      <= a;
    words_i     <= n;
    out_ready_i <= 1'b1;
    mem_wait    <= 2'd0;
    while (got < int'(n) && cyc < TIMEOUT) begin
      @(posedge clk_i);
      start_i <= poke && (cyc == 2);
      if (poke && cyc == 2) begin
        addr_i <= a + 32'h80;
      end
      if (bp) begin
        r = rand_bits(1);
        out_ready_i <= r[0];
      end
      if (ws) begin
        r = rand_bits(2);
        mem_wait <= r[1:0];
      end
      @(negedge clk_i);
      // bus cycles are reads only
      if (wb_cyc_o) begin
        check_last("wb_we_o", wb_we_o, 1'b0);
      end
      if (out_valid_o && out_ready_i) begin
        check_data("out_data_o", out_data_o, model_word(a, got));
        check_last("out_last_o", out_last_o, got == int'(n) - 1);
        got++;
      end
      cyc++;
    end
    if (got < int'(n)) begin
      $display("timeout in %s: only %0d of %0d words came out", what, got, n);
      errors++;
    end
    cyc = 0;
    while (busy_o && cyc < TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (busy_o) begin
      $display("busy_o did not fall after %s", what);
      errors++;
    end
    check_last("out_valid_o", out_valid_o, 1'b0);
    tests++;
    $display("test %0d %s: addr %08h, %0d words, %s", tests, what, a, n,
             (errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    logic [31:0] r;
    addr_t       a;
    len_t        n;
    lfsr_q      = 32'hc823;
    errors      = 0;
    tests       = 0;
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    addr_i      = '0;
    words_i     = '0;
    out_ready_i = 1'b0;
    mem_wait    = 2'd0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      r = rand_bits(32);
      model_mem[i]   = r;
      u_mem.mem_q[i] = r;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_last("busy_o", busy_o, 1'b0);
    check_last("out_valid_o", out_valid_o, 1'b0);
    check_last("wb_cyc_o", wb_cyc_o, 1'b0);
    check_last("wb_stb_o", wb_stb_o, 1'b0);

    run_transfer("aligned", 32'h40, 16'd8, 1'b0, 1'b0, 1'b0);
    for (int o = 1; o < 4; o++) begin
      run_transfer("offset", 32'h100 + addr_t'(o), 16'd5, 1'b0, 1'b0, 1'b0);
    end
    // word index up to 127 leaves room for 9 fetches
    for (int t = 0; t < 12; t++) begin
      r = rand_bits(9);
      a = addr_t'(r[8:0]);
      r = rand_bits(3);
      n = len_t'(r[2:0]) + 1'b1;
      run_transfer("random", a, n, t[0], t[1], 1'b0);
    end
    run_transfer("start while busy", 32'h1c2, 16'd6, 1'b1, 1'b1, 1'b1);
    run_transfer("after ignored start", 32'h1c2, 16'd6, 1'b0, 1'b0, 1'b0);
    run_transfer("one word", 32'h203, 16'd1, 1'b1, 1'b1, 1'b0);

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/tb_wb_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave memory for the testbench
// read-only slave that acks after 0 to 3 extra wait cycles set by wait_i
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_wb_mem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  stream_pkg::addr_t adr_i,
  input  logic [1:0]        wait_i,
  output stream_pkg::data_t dat_o,
  output logic              ack_o
);

  import stream_pkg::*;

  // filled by the testbench at time 0
  data_t      mem_q [256];
  logic [1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      cnt_q <= '0;
      dat_o <= '0;
    end else begin
      // ack is a single-cycle pulse that never comes in the cycle stb rises
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        if (cnt_q >= wait_i) begin
          ack_o <= 1'b1;
          dat_o <= mem_q[adr_i[9:2]];
          cnt_q <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

endmodule
